// ==== src/gpio_defs.svh ====
// Build-time constants for the GPIO block.
// Include in any file that needs pin count, bus widths or register offsets.
// Offsets are byte addresses on the APB side, word aligned.

`ifndef GPIO_DEFS_SVH
`define GPIO_DEFS_SVH

// default pin count
`define GPIO_WIDTH 12

// APB bus geometry
`define APB_AW 12
`define APB_DW 32

// register map
`define REG_IN_VAL  12'h000     // read-only, masked pins
`define REG_IN_EN   12'h004     // input enable, also pin direction
`define REG_OUT_EN  12'h008
`define REG_OUT_VAL 12'h00C
`define REG_IE      12'h010     // interrupt enable
`define REG_IP      12'h014     // interrupt pending

`endif

// ==== src/gpio_pkg.sv ====
// Shared types for the GPIO block and its testbench.
// Import with a wildcard in the module header.

`include "gpio_defs.svh"

package gpio_pkg;

    // one APB data word
    typedef logic [`APB_DW-1:0] bus_word_t;

    // pin vector at the default pin count
    typedef logic [`GPIO_WIDTH-1:0] pin_vec_t;

    // register index, same as word address bits 4:2
    typedef enum logic [2:0] {
        idx_in_val  = 3'd0,
        idx_in_en   = 3'd1,
        idx_out_en  = 3'd2,
        idx_out_val = 3'd3,
        idx_ie      = 3'd4,
        idx_ip      = 3'd5,
        idx_invalid = 3'd7     // anything outside the map
    } gpio_reg_e;

endpackage

// ==== src/apb_slave_port.sv ====
// APB slave front end.
// Turns each APB transfer into a single-cycle register request and
// holds the access phase until the register file answers.
// Address, direction and write data are captured in the setup phase.

`include "gpio_defs.svh"

module apb_slave_port
    import gpio_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [`APB_AW-1:0] i_paddr,
    input  bus_word_t          i_pwdata,
    output bus_word_t          o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    output logic               o_req_valid,
    output logic [`APB_AW-1:0] o_req_addr,
    output logic               o_req_write,
    output bus_word_t          o_req_wdata,
    input  logic               i_resp_valid,
    input  bus_word_t          i_resp_rdata,
    input  logic               i_resp_err
);

    typedef enum logic [1:0] {
        st_idle    = 2'd0,
        st_request = 2'd1,
        st_wait    = 2'd2
    } port_state_e;

    port_state_e       state;
    port_state_e       state_nxt;
    logic              setup_phase;
    logic [`APB_AW-1:0] addr_q;
    logic              write_q;
    bus_word_t         wdata_q;

    assign setup_phase = i_psel && !i_penable;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (setup_phase) begin
                    state_nxt = st_request;
                end
            end
            st_request: begin
                state_nxt = st_wait;     // request lasts one cycle only
            end
            st_wait: begin
                if (i_resp_valid) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // transfer attributes captured once per transfer
    always_ff @(posedge i_clk) begin
        if (state == st_idle && setup_phase) begin
            addr_q  <= i_paddr;
            write_q <= i_pwrite;
            wdata_q <= i_pwdata;
        end
    end

    assign o_req_valid = (state == st_request);
    assign o_req_addr  = addr_q;
    assign o_req_write = write_q;
    assign o_req_wdata = wdata_q;

    // completion comes straight from the registered response
    assign o_pready  = (state == st_wait) && i_resp_valid;
    assign o_pslverr = o_pready && i_resp_err;
    assign o_prdata  = o_pready ? i_resp_rdata : '0;

    // master must not raise penable outside a selected transfer
    a_penable_needs_psel: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_penable |-> i_psel
    );

    // each request is answered in the next cycle and never repeated
    a_req_single_pulse: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_req_valid |=> (!o_req_valid && i_resp_valid)
    );

endmodule

// ==== src/gpio_regs.sv ====
// GPIO register file behind the APB slave port.
// Holds pin direction, output value and interrupt state, samples the pins
// through the input enables and answers each request one cycle later.
// Pending bits set on a rising edge of a sampled input.

`include "gpio_defs.svh"

module gpio_regs
    import gpio_pkg::*;
#(
    parameter int width = `GPIO_WIDTH
) (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_req_valid,
    input  logic [`APB_AW-1:0] i_req_addr,
    input  logic               i_req_write,
    input  bus_word_t          i_req_wdata,
    input  logic [width-1:0]   i_gpio,
    output logic               o_resp_valid,
    output bus_word_t          o_resp_rdata,
    output logic               o_resp_err,
    output logic [width-1:0]   o_gpio,
    output logic [width-1:0]   o_gpio_dir,
    output logic [width-1:0]   o_irq
);

    logic [width-1:0] in_val;
    logic [width-1:0] in_prev;     // previous sample for edge detect
    logic [width-1:0] in_en;
    logic [width-1:0] out_en;
    logic [width-1:0] out_val;
    logic [width-1:0] ie;
    logic [width-1:0] ip;

    gpio_reg_e        reg_idx;
    logic             wr_en;
    logic [width-1:0] wr_bits;
    logic [width-1:0] rise;
    bus_word_t        rd_word;

    // byte address to register index with the low two bits ignored
    function automatic gpio_reg_e decode_reg(input logic [`APB_AW-1:0] addr);
        logic [`APB_AW-1:0] word_addr;
        word_addr = {addr[`APB_AW-1:2], 2'b00};
        case (word_addr)
            `REG_IN_VAL:  decode_reg = idx_in_val;
            `REG_IN_EN:   decode_reg = idx_in_en;
            `REG_OUT_EN:  decode_reg = idx_out_en;
            `REG_OUT_VAL: decode_reg = idx_out_val;
            `REG_IE:      decode_reg = idx_ie;
            `REG_IP:      decode_reg = idx_ip;
            default:      decode_reg = idx_invalid;
        endcase
    endfunction

    assign reg_idx = decode_reg(i_req_addr);
    assign wr_en   = i_req_valid && i_req_write;
    assign wr_bits = i_req_wdata[width-1:0];
    assign rise    = in_val & ~in_prev;     // 0 to 1 on a masked input

    always_comb begin
        rd_word = '0;     // unmapped reads return zero
        case (reg_idx)
            idx_in_val:  rd_word[width-1:0] = in_val;
            idx_in_en:   rd_word[width-1:0] = in_en;
            idx_out_en:  rd_word[width-1:0] = out_en;
            idx_out_val: rd_word[width-1:0] = out_val;
            idx_ie:      rd_word[width-1:0] = ie;
            idx_ip:      rd_word[width-1:0] = ip;
            default: begin
            end
        endcase
    end

    // software writable registers
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            in_en   <= '1;     // all pins start as inputs
            out_en  <= '0;
            out_val <= '0;
            ie      <= '0;
        end else if (wr_en) begin
            case (reg_idx)
                idx_in_en:   in_en   <= wr_bits;
                idx_out_en:  out_en  <= wr_bits;
                idx_out_val: out_val <= wr_bits;
                idx_ie:      ie      <= wr_bits;
                default: begin
                end
            endcase
        end
    end

    // pin sampling and interrupt capture
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            in_val  <= '0;
            in_prev <= '0;
            ip      <= '0;
        end else begin
            in_val  <= i_gpio & in_en;
            in_prev <= in_val;
            if (wr_en && reg_idx == idx_ip) begin
                ip <= wr_bits;     // software write beats a new edge
            end else begin
                ip <= ip | rise;
            end
        end
    end

    // response one cycle after the request
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_resp_valid <= 1'b0;
            o_resp_err   <= 1'b0;
        end else begin
            o_resp_valid <= i_req_valid;
            o_resp_err   <= i_req_valid && (reg_idx == idx_invalid);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            o_resp_rdata <= rd_word;
        end
    end

    assign o_gpio     = out_val;
    assign o_gpio_dir = in_en;     // 1 means input
    assign o_irq      = ie & ip;

    // no new request arrives while a response is out
    a_resp_no_overlap: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid |-> !i_req_valid
    );

endmodule

// ==== src/gpio_top.sv ====
// GPIO block with an APB slave interface.
// The slave port turns bus transfers into register requests,
// the register file drives the pins and the interrupt lines.

`include "gpio_defs.svh"

module gpio_top
    import gpio_pkg::*;
#(
    parameter int width = `GPIO_WIDTH
) (
    input  logic               i_clk,
    input  logic               i_nrst,
    input  logic               i_psel,
    input  logic               i_penable,
    input  logic               i_pwrite,
    input  logic [`APB_AW-1:0] i_paddr,
    input  bus_word_t          i_pwdata,
    output bus_word_t          o_prdata,
    output logic               o_pready,
    output logic               o_pslverr,
    input  logic [width-1:0]   i_gpio,
    output logic [width-1:0]   o_gpio,
    output logic [width-1:0]   o_gpio_dir,
    output logic [width-1:0]   o_irq
);

    // request and response between port and registers
    logic               req_valid;
    logic [`APB_AW-1:0] req_addr;
    logic               req_write;
    bus_word_t          req_wdata;
    logic               resp_valid;
    bus_word_t          resp_rdata;
    logic               resp_err;

    apb_slave_port u_apb (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .o_req_valid  (req_valid),
        .o_req_addr   (req_addr),
        .o_req_write  (req_write),
        .o_req_wdata  (req_wdata),
        .i_resp_valid (resp_valid),
        .i_resp_rdata (resp_rdata),
        .i_resp_err   (resp_err)
    );

    gpio_regs #(
        .width (width)
    ) u_regs (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req_valid  (req_valid),
        .i_req_addr   (req_addr),
        .i_req_write  (req_write),
        .i_req_wdata  (req_wdata),
        .i_gpio       (i_gpio),
        .o_resp_valid (resp_valid),
        .o_resp_rdata (resp_rdata),
        .o_resp_err   (resp_err),
        .o_gpio       (o_gpio),
        .o_gpio_dir   (o_gpio_dir),
        .o_irq        (o_irq)
    );

endmodule

// ==== verif/tb_gpio.sv ====
// Testbench for the APB GPIO block.
// Replays verif/gpio_vectors.txt against gpio_top, then runs a seeded random
// write and read-back pass over the writable registers.
// Run the simulation from the project root so the vector path resolves.

`include "gpio_defs.svh"

module tb_gpio
    import gpio_pkg::*;
();

    localparam int pins       = `GPIO_WIDTH;
    localparam int max_wait   = 20;     // cycles allowed for pready
    localparam int pin_settle = 3;
    localparam bus_word_t width_mask = bus_word_t'((64'd1 << pins) - 64'd1);

    logic               clk;
    logic               nrst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [`APB_AW-1:0] paddr;
    bus_word_t          pwdata;
    bus_word_t          prdata;
    logic               pready;
    logic               pslverr;
    pin_vec_t           gpio_in;
    pin_vec_t           gpio_out;
    pin_vec_t           gpio_dir;
    pin_vec_t           irq;

    int seed;
    int value_errors;
    int timeout_errors;
    int file_errors;

    gpio_top #(
        .width (pins)
    ) dut_i (
        .i_clk      (clk),
        .i_nrst     (nrst),
        .i_psel     (psel),
        .i_penable  (penable),
        .i_pwrite   (pwrite),
        .i_paddr    (paddr),
        .i_pwdata   (pwdata),
        .o_prdata   (prdata),
        .o_pready   (pready),
        .o_pslverr  (pslverr),
        .i_gpio     (gpio_in),
        .o_gpio     (gpio_out),
        .o_gpio_dir (gpio_dir),
        .o_irq      (irq)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    task automatic check_word(input string name, input bus_word_t exp, input bus_word_t act);
        if (act !== exp) begin
            $display("Error %s expected 0x%h got 0x%h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_pins(input string name, input pin_vec_t exp, input pin_vec_t act);
        if (act !== exp) begin
            $display("Error %s expected 0x%h got 0x%h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s expected 0x%h got 0x%h", name, exp, act);
            value_errors++;
        end
    endtask

    // map ends at the pending register
    function automatic logic is_unmapped(input logic [`APB_AW-1:0] addr);
        return {addr[`APB_AW-1:2], 2'b00} > `REG_IP;
    endfunction

    // setup phase then access phase until pready or timeout
    task automatic apb_transfer(input logic write, input logic [`APB_AW-1:0] addr,
                                input bus_word_t wdata, output bus_word_t rdata,
                                output logic err);
        int   cycles;
        logic done;
        rdata  = '0;
        err    = 1'b0;
        done   = 1'b0;
        cycles = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        while (!done && cycles < max_wait) begin
            @(negedge clk);     // outputs settled here
            if (pready) begin
                done  = 1'b1;
                rdata = prdata;
                err   = pslverr;
            end
            cycles++;
        end
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        if (!done) begin
            $display("APB transfer at address 0x%h got no pready within %0d cycles",
                     addr, max_wait);
            timeout_errors++;
        end
    endtask

    task automatic apb_write(input logic [`APB_AW-1:0] addr, input bus_word_t data,
                             output logic err);
        bus_word_t ignored;
        apb_transfer(1'b1, addr, data, ignored, err);
    endtask

    task automatic apb_read(input logic [`APB_AW-1:0] addr, output bus_word_t data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic drive_pins(input pin_vec_t value);
        @(posedge clk);
        gpio_in <= value;
        repeat (pin_settle) @(posedge clk);     // sample plus edge capture
    endtask

    task automatic run_vectors();
        int                 fd;
        int                 n;
        int                 ops;
        string              line;
        logic [7:0]         op;
        logic [`APB_AW-1:0] addr;
        bus_word_t          data;
        logic [63:0]        expv;
        bus_word_t          rdata;
        logic               err;
        ops = 0;
        fd  = $fopen("verif/gpio_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file verif/gpio_vectors.txt");
            file_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h", op, addr, data, expv);
            if (n != 4 || op == "#") begin
                continue;     // blank or comment
            end
            ops++;
            case (op)
                "W": begin
                    apb_write(addr, data, err);
                    check_flag("o_pslverr", is_unmapped(addr), err);
                end
                "R": begin
                    apb_read(addr, rdata, err);
                    check_word("o_prdata", expv[`APB_DW-1:0], rdata);
                    check_flag("o_pslverr", is_unmapped(addr), err);
                end
                "P": drive_pins(data[pins-1:0]);
                "O": begin
                    @(negedge clk);
                    check_pins("o_gpio", expv[3*pins-1:2*pins], gpio_out);
                    check_pins("o_gpio_dir", expv[2*pins-1:pins], gpio_dir);
                    check_pins("o_irq", expv[pins-1:0], irq);
                end
                default: begin
                    $display("unknown operation in vector line: %s", line);
                    file_errors++;
                end
            endcase
        end
        $fclose(fd);
        if (ops == 0) begin
            $display("the vector file held no operations");
            file_errors++;
        end
    endtask

    task automatic readback_random(input logic [`APB_AW-1:0] addr, input string name,
                                   output pin_vec_t kept);
        bus_word_t wdata;
        bus_word_t rdata;
        logic      err;
        wdata = $random(seed);
        apb_write(addr, wdata, err);
        check_flag("o_pslverr", 1'b0, err);
        apb_read(addr, rdata, err);
        check_flag("o_pslverr", 1'b0, err);
        check_word(name, wdata & width_mask, rdata);
        kept = wdata[pins-1:0];
    endtask

    task automatic random_pass();
        pin_vec_t in_en;
        pin_vec_t out_en;
        pin_vec_t out_val;
        pin_vec_t ie;
        pin_vec_t ip;
        drive_pins('0);     // quiet pins so no edges reach pending
        readback_random(`REG_IN_EN, "o_prdata (in_en)", in_en);
        readback_random(`REG_OUT_EN, "o_prdata (out_en)", out_en);
        readback_random(`REG_OUT_VAL, "o_prdata (out_val)", out_val);
        readback_random(`REG_IE, "o_prdata (ie)", ie);
        readback_random(`REG_IP, "o_prdata (ip)", ip);
        @(negedge clk);
        check_pins("o_gpio", out_val, gpio_out);
        check_pins("o_gpio_dir", in_en, gpio_dir);
        check_pins("o_irq", ie & ip, irq);
    endtask

    initial begin
        seed           = 44090;
        value_errors   = 0;
        timeout_errors = 0;
        file_errors    = 0;
        nrst    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        gpio_in = '0;
        repeat (16) @(posedge clk);
        nrst <= 1'b1;
        run_vectors();
        random_pass();
        $display("errors: %0d value, %0d timeout, %0d vector file",
                 value_errors, timeout_errors, file_errors);
        if (value_errors + timeout_errors + file_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/gpio_vectors.txt ====
# columns: op addr data expected, all hex; W write, R read, P drive pins, O check pins
# O expected packs {o_gpio, o_gpio_dir, o_irq}, 12 bits each
# reset values
R 000 00000000 00000000
R 004 00000000 00000FFF
R 008 00000000 00000000
R 00C 00000000 00000000
R 010 00000000 00000000
R 014 00000000 00000000
O 000 00000000 000FFF000
# write and read back
W 008 00000F0F 00000000
R 008 00000000 00000F0F
W 00C 00000ABC 00000000
R 00C 00000000 00000ABC
W 00C FFFFF5A5 00000000
R 00C 00000000 000005A5
W 004 0000F0F0 00000000
R 004 00000000 000000F0
O 000 00000000 5A50F0000
# input masking
P 000 00000FFF 00000000
R 000 00000000 000000F0
R 014 00000000 000000F0
W 014 00000000 00000000
R 014 00000000 00000000
P 000 00000000 00000000
R 000 00000000 00000000
# interrupts
W 010 0000000F 00000000
W 004 00000FFF 00000000
P 000 00000005 00000000
R 014 00000000 00000005
O 000 00000000 5A5FFF005
P 000 00000105 00000000
R 014 00000000 00000105
O 000 00000000 5A5FFF005
W 014 00000000 00000000
O 000 00000000 5A5FFF000
R 000 00000000 00000105
P 000 00000000 00000000
R 014 00000000 00000000
P 000 0000000A 00000000
O 000 00000000 5A5FFF00A
W 010 00000000 00000000
O 000 00000000 5A5FFF000
R 014 00000000 0000000A
# narrower input enable
W 004 0000000F 00000000
P 000 00000F3C 00000000
R 000 00000000 0000000C
R 014 00000000 0000000E
O 000 00000000 5A500F000
# unmapped addresses
R 018 00000000 00000000
R 01C 00000000 00000000
R 100 00000000 00000000
R FFC 00000000 00000000
W 018 00000123 00000000
R 00C 00000000 000005A5

// ==== files.f ====
+incdir+src
src/gpio_pkg.sv
src/apb_slave_port.sv
src/gpio_regs.sv
src/gpio_top.sv
verif/tb_gpio.sv

// ==== Makefile ====
# Verilator build and run for the APB GPIO block.
# Run from the project root; variables can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_gpio
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) src/gpio_defs.svh

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
